// ==== verilog/periph_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Address map, register offsets, bus structs and write-strobe helpers
// for the peripheral subsystem
//////////////////////////////////////////////////////////////////////
package periph_pkg;

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [STRB_WIDTH-1:0] be;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic                  err;
    logic [DATA_WIDTH-1:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [STRB_WIDTH-1:0] wstrb;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                  ready;
    logic                  error;
    logic [DATA_WIDTH-1:0] rdata;
  } reg_rsp_t;

  // Targets and address map
  localparam int NUM_PERIPH   = 3;
  localparam int IRQ_CTRL_IDX = 0;
  localparam int GPIO_IDX     = 1;
  localparam int TIMER_IDX    = 2;

  localparam logic [ADDR_WIDTH-1:0] IRQ_CTRL_BASE = 32'h2000_0000;
  localparam logic [ADDR_WIDTH-1:0] GPIO_BASE     = 32'h2000_1000;
  localparam logic [ADDR_WIDTH-1:0] TIMER_BASE    = 32'h2000_2000;
  // Power of two, bases aligned to it
  localparam logic [ADDR_WIDTH-1:0] PERIPH_WINDOW = 32'h0000_1000;
  localparam int OFFSET_WIDTH = $clog2(PERIPH_WINDOW);

  // Indexed by target index
  localparam logic [NUM_PERIPH-1:0][ADDR_WIDTH-1:0] PERIPH_BASE =
    {TIMER_BASE, GPIO_BASE, IRQ_CTRL_BASE};

  // GPIO
  localparam int GPIO_WIDTH = 32;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_DATA_IN     = 'h00;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_DATA_OUT    = 'h04;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_OUT_EN      = 'h08;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_INTR_EN     = 'h0C;
  localparam logic [OFFSET_WIDTH-1:0] GPIO_INTR_STATUS = 'h10;

  // Timer
  localparam int MTIME_WIDTH    = 64;
  localparam int PRESCALE_WIDTH = 8;
  localparam logic [OFFSET_WIDTH-1:0] TIMER_MTIME_LO = 'h00;
  localparam logic [OFFSET_WIDTH-1:0] TIMER_MTIME_HI = 'h04;
  localparam logic [OFFSET_WIDTH-1:0] TIMER_CMP_LO   = 'h08;
  localparam logic [OFFSET_WIDTH-1:0] TIMER_CMP_HI   = 'h0C;
  localparam logic [OFFSET_WIDTH-1:0] TIMER_CTRL     = 'h10;

  // Interrupt controller
  localparam int NUM_EXT_IRQ  = 5;
  localparam int NUM_IRQ_SRC  = 8;
  localparam int IRQ_ID_WIDTH = 3;
  localparam logic [OFFSET_WIDTH-1:0] IRQ_PENDING = 'h00;
  localparam logic [OFFSET_WIDTH-1:0] IRQ_ENABLE  = 'h04;
  localparam logic [OFFSET_WIDTH-1:0] IRQ_CLAIM   = 'h08;
  localparam logic [OFFSET_WIDTH-1:0] IRQ_MSIP    = 'h0C;

  function automatic logic [DATA_WIDTH-1:0] strb_mask(input logic [STRB_WIDTH-1:0] strb);
    logic [DATA_WIDTH-1:0] mask;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

  // Merge written bytes into an old register value
  function automatic logic [DATA_WIDTH-1:0] apply_wstrb(input logic [DATA_WIDTH-1:0] old,
                                                         input logic [DATA_WIDTH-1:0] wdata,
                                                         input logic [STRB_WIDTH-1:0] strb);
    logic [DATA_WIDTH-1:0] mask;
    mask = strb_mask(strb);
    return (old & ~mask) | (wdata & mask);
  endfunction

endpackage

// ==== verilog/obi_to_reg.sv ====
//////////////////////////////////////////////////////////////////////
// OBI to register-bus bridge, one transfer in flight
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module obi_to_reg (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  periph_pkg::obi_req_t  obi_req_i,
  output periph_pkg::obi_resp_t obi_resp_o,
  output periph_pkg::reg_req_t  reg_req_o,
  input  periph_pkg::reg_rsp_t  reg_rsp_i
);

  typedef enum logic {ST_IDLE, ST_BUSY} state_e;

  state_e                                state_q;
  logic                                  rvalid_q;
  logic                                  err_q;
  logic [periph_pkg::DATA_WIDTH-1:0]     rdata_q;
  logic                                  we_q;
  logic [periph_pkg::STRB_WIDTH-1:0]     be_q;
  logic [periph_pkg::ADDR_WIDTH-1:0]     addr_q;
  logic [periph_pkg::DATA_WIDTH-1:0]     wdata_q;
  logic                                  accept;
  logic                                  done;

  assign accept = obi_req_i.req && (state_q == ST_IDLE);
  assign done   = (state_q == ST_BUSY) && reg_rsp_i.ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= done;
      if (accept) begin
        state_q <= ST_BUSY;
      end else if (done) begin
        state_q <= ST_IDLE;
      end
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q    <= obi_req_i.we;
      be_q    <= obi_req_i.be;
      addr_q  <= obi_req_i.addr;
      wdata_q <= obi_req_i.wdata;
    end
    if (done) begin
      rdata_q <= reg_rsp_i.rdata;
      err_q   <= reg_rsp_i.error;
    end
  end

  assign reg_req_o = '{valid: (state_q == ST_BUSY), write: we_q, wstrb: be_q,
                       addr: addr_q, wdata: wdata_q};

  // Grant again in the rvalid cycle
  assign obi_resp_o = '{gnt: (state_q == ST_IDLE), rvalid: rvalid_q, err: err_q,
                        rdata: rdata_q};

  // A response only closes a transfer that held the grant low
  rvalid_needs_transfer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    obi_resp_o.rvalid |-> $past(!obi_resp_o.gnt));

  req_stable_until_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_req_o.valid && !reg_rsp_i.ready |=> $stable(reg_req_o));

endmodule

// ==== verilog/reg_demux.sv ====
//////////////////////////////////////////////////////////////////////
// Register-bus address decoder and demultiplexer with error response
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reg_demux (
  input  periph_pkg::reg_req_t                             reg_req_i,
  output periph_pkg::reg_rsp_t                             reg_rsp_o,
  output periph_pkg::reg_req_t [periph_pkg::NUM_PERIPH-1:0] periph_req_o,
  input  periph_pkg::reg_rsp_t [periph_pkg::NUM_PERIPH-1:0] periph_rsp_i
);

  logic [periph_pkg::NUM_PERIPH-1:0] hit;
  logic [periph_pkg::NUM_PERIPH-1:0] fwd_valid;
  logic [periph_pkg::ADDR_WIDTH-1:0] win_addr;

  // Window base of the incoming address
  assign win_addr = reg_req_i.addr & ~(periph_pkg::PERIPH_WINDOW - 1);

  always_comb begin
    for (int i = 0; i < periph_pkg::NUM_PERIPH; i++) begin
      hit[i]                = (win_addr == periph_pkg::PERIPH_BASE[i]);
      fwd_valid[i]          = reg_req_i.valid && hit[i];
      periph_req_o[i]       = reg_req_i;
      periph_req_o[i].valid = fwd_valid[i];
    end
  end

  always_comb begin
    // Miss answered here
    reg_rsp_o = '{ready: reg_req_i.valid, error: 1'b1, rdata: '0};
    for (int i = 0; i < periph_pkg::NUM_PERIPH; i++) begin
      if (hit[i]) begin
        reg_rsp_o = periph_rsp_i[i];
      end
    end
  end

  always_comb begin
    one_port_valid: assert #0 ($onehot0(fwd_valid));
  end

endmodule

// ==== verilog/gpio.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO with input synchronizers, output enables, rising-edge interrupts
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gpio (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  periph_pkg::reg_req_t              reg_req_i,
  output periph_pkg::reg_rsp_t              reg_rsp_o,
  input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_i,
  output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_o,
  output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_en_o,
  output logic                              irq_o
);

  logic [periph_pkg::GPIO_WIDTH-1:0]   sync1_q;
  logic [periph_pkg::GPIO_WIDTH-1:0]   sync2_q;
  logic [periph_pkg::GPIO_WIDTH-1:0]   prev_q;
  logic [periph_pkg::GPIO_WIDTH-1:0]   data_out_q;
  logic [periph_pkg::GPIO_WIDTH-1:0]   out_en_q;
  logic [periph_pkg::GPIO_WIDTH-1:0]   intr_en_q;
  logic [periph_pkg::GPIO_WIDTH-1:0]   status_q;
  logic [periph_pkg::GPIO_WIDTH-1:0]   rise;
  logic [periph_pkg::GPIO_WIDTH-1:0]   status_clr;
  logic [periph_pkg::OFFSET_WIDTH-1:0] offset;
  logic                                wr;

  assign offset = reg_req_i.addr[periph_pkg::OFFSET_WIDTH-1:0];
  assign wr     = reg_req_i.valid && reg_req_i.write;
  assign rise   = sync2_q & ~prev_q & intr_en_q;

  // Write 1 to clear, only in strobed bytes
  assign status_clr = (wr && offset == periph_pkg::GPIO_INTR_STATUS) ?
                      reg_req_i.wdata & periph_pkg::strb_mask(reg_req_i.wstrb) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q    <= '0;
      sync2_q    <= '0;
      prev_q     <= '0;
      data_out_q <= '0;
      out_en_q   <= '0;
      intr_en_q  <= '0;
      status_q   <= '0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      // New edge wins over a clear
      status_q <= (status_q & ~status_clr) | rise;
      if (wr && offset == periph_pkg::GPIO_DATA_OUT) begin
        data_out_q <= periph_pkg::apply_wstrb(data_out_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (wr && offset == periph_pkg::GPIO_OUT_EN) begin
        out_en_q <= periph_pkg::apply_wstrb(out_en_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (wr && offset == periph_pkg::GPIO_INTR_EN) begin
        intr_en_q <= periph_pkg::apply_wstrb(intr_en_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    case (offset)
      periph_pkg::GPIO_DATA_IN:     reg_rsp_o.rdata = sync2_q;
      periph_pkg::GPIO_DATA_OUT:    reg_rsp_o.rdata = data_out_q;
      periph_pkg::GPIO_OUT_EN:      reg_rsp_o.rdata = out_en_q;
      periph_pkg::GPIO_INTR_EN:     reg_rsp_o.rdata = intr_en_q;
      periph_pkg::GPIO_INTR_STATUS: reg_rsp_o.rdata = status_q;
      default:                      reg_rsp_o.rdata = '0;
    endcase
  end

  assign gpio_o    = data_out_q;
  assign gpio_en_o = out_en_q;
  assign irq_o     = |status_q;

endmodule

// ==== verilog/rv_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Machine timer with prescaler, 64-bit mtime and compare
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_timer (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                 irq_o
);

  logic [periph_pkg::MTIME_WIDTH-1:0]    mtime_q;
  logic [periph_pkg::MTIME_WIDTH-1:0]    mtime_nxt;
  logic [periph_pkg::MTIME_WIDTH-1:0]    cmp_q;
  logic [periph_pkg::PRESCALE_WIDTH-1:0] prescale_q;
  logic [periph_pkg::PRESCALE_WIDTH-1:0] presc_cnt_q;
  logic                                  enable_q;
  logic                                  tick;
  logic [periph_pkg::OFFSET_WIDTH-1:0]   offset;
  logic                                  wr;

  assign offset = reg_req_i.addr[periph_pkg::OFFSET_WIDTH-1:0];
  assign wr     = reg_req_i.valid && reg_req_i.write;
  // One tick every prescale+1 cycles
  assign tick   = enable_q && (presc_cnt_q == prescale_q);

  always_comb begin
    mtime_nxt = mtime_q + periph_pkg::MTIME_WIDTH'(tick);
    // Software write overrides the count in that half
    if (wr && offset == periph_pkg::TIMER_MTIME_LO) begin
      mtime_nxt[31:0] = periph_pkg::apply_wstrb(mtime_q[31:0], reg_req_i.wdata, reg_req_i.wstrb);
    end
    if (wr && offset == periph_pkg::TIMER_MTIME_HI) begin
      mtime_nxt[63:32] = periph_pkg::apply_wstrb(mtime_q[63:32], reg_req_i.wdata,
                                                 reg_req_i.wstrb);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q     <= '0;
      cmp_q       <= '1;
      enable_q    <= 1'b0;
      prescale_q  <= '0;
      presc_cnt_q <= '0;
    end else begin
      mtime_q <= mtime_nxt;
      if (!enable_q || tick) begin
        presc_cnt_q <= '0;
      end else begin
        presc_cnt_q <= presc_cnt_q + 1'b1;
      end
      if (wr && offset == periph_pkg::TIMER_CMP_LO) begin
        cmp_q[31:0] <= periph_pkg::apply_wstrb(cmp_q[31:0], reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (wr && offset == periph_pkg::TIMER_CMP_HI) begin
        cmp_q[63:32] <= periph_pkg::apply_wstrb(cmp_q[63:32], reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (wr && offset == periph_pkg::TIMER_CTRL) begin
        if (reg_req_i.wstrb[0]) enable_q <= reg_req_i.wdata[0];
        if (reg_req_i.wstrb[1]) prescale_q <= reg_req_i.wdata[15:8];
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    case (offset)
      periph_pkg::TIMER_MTIME_LO: reg_rsp_o.rdata = mtime_q[31:0];
      periph_pkg::TIMER_MTIME_HI: reg_rsp_o.rdata = mtime_q[63:32];
      periph_pkg::TIMER_CMP_LO:   reg_rsp_o.rdata = cmp_q[31:0];
      periph_pkg::TIMER_CMP_HI:   reg_rsp_o.rdata = cmp_q[63:32];
      periph_pkg::TIMER_CTRL:     reg_rsp_o.rdata = {16'b0, prescale_q, 7'b0, enable_q};
      default:                    reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o = (mtime_q >= cmp_q);

endmodule

// ==== verilog/irq_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt controller with gateways, claim/complete and MSIP
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  periph_pkg::reg_req_t               reg_req_i,
  output periph_pkg::reg_rsp_t               reg_rsp_o,
  input  logic [periph_pkg::NUM_IRQ_SRC-1:0] irq_src_i,
  output logic                               irq_o,
  output logic                               msip_o
);

  localparam int N = periph_pkg::NUM_IRQ_SRC;

  logic [N-1:0]                        pending_q;
  logic [N-1:0]                        enable_q;
  logic [N-1:0]                        in_service_q;
  logic [N-1:0]                        active;
  logic [N-1:0]                        gw_set;
  logic [N-1:0]                        claim_set;
  logic [N-1:0]                        complete_clr;
  logic [periph_pkg::IRQ_ID_WIDTH-1:0] claim_id;
  logic [periph_pkg::OFFSET_WIDTH-1:0] offset;
  logic                                msip_q;
  logic                                wr;
  logic                                claim_rd;

  assign offset   = reg_req_i.addr[periph_pkg::OFFSET_WIDTH-1:0];
  assign wr       = reg_req_i.valid && reg_req_i.write;
  assign claim_rd = reg_req_i.valid && !reg_req_i.write && offset == periph_pkg::IRQ_CLAIM;
  assign active   = pending_q & enable_q;

  // Lowest enabled pending ID, 0 when none
  always_comb begin
    claim_id = '0;
    for (int i = N - 1; i > 0; i--) begin
      if (active[i]) claim_id = periph_pkg::IRQ_ID_WIDTH'(i);
    end
  end

  // Gateway, source 0 ignored
  assign gw_set = {irq_src_i[N-1:1] & ~pending_q[N-1:1] & ~in_service_q[N-1:1], 1'b0};

  assign claim_set    = (claim_rd && claim_id != '0) ? (N'(1) << claim_id) : '0;
  assign complete_clr = (wr && offset == periph_pkg::IRQ_CLAIM && reg_req_i.wstrb[0]) ?
                        (N'(1) << reg_req_i.wdata[periph_pkg::IRQ_ID_WIDTH-1:0]) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q    <= '0;
      enable_q     <= '0;
      in_service_q <= '0;
      msip_q       <= 1'b0;
    end else begin
      pending_q    <= (pending_q & ~claim_set) | gw_set;
      in_service_q <= (in_service_q & ~complete_clr) | claim_set;
      if (wr && offset == periph_pkg::IRQ_ENABLE) begin
        enable_q <= N'(periph_pkg::apply_wstrb(periph_pkg::DATA_WIDTH'(enable_q),
                                               reg_req_i.wdata, reg_req_i.wstrb));
      end
      if (wr && offset == periph_pkg::IRQ_MSIP && reg_req_i.wstrb[0]) begin
        msip_q <= reg_req_i.wdata[0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    case (offset)
      periph_pkg::IRQ_PENDING: reg_rsp_o.rdata = periph_pkg::DATA_WIDTH'(pending_q);
      periph_pkg::IRQ_ENABLE:  reg_rsp_o.rdata = periph_pkg::DATA_WIDTH'(enable_q);
      periph_pkg::IRQ_CLAIM:   reg_rsp_o.rdata = periph_pkg::DATA_WIDTH'(claim_id);
      periph_pkg::IRQ_MSIP:    reg_rsp_o.rdata = periph_pkg::DATA_WIDTH'(msip_q);
      default:                 reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o  = |active;
  assign msip_o = msip_q;

  claim_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    claim_rd |-> int'(claim_id) < N);

  src0_never_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !pending_q[0]);

endmodule

// ==== verilog/peripheral_subsystem.sv ====
//////////////////////////////////////////////////////////////////////
// Peripheral subsystem top with bridge, demux, GPIO, timer and IRQs
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module peripheral_subsystem (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  periph_pkg::obi_req_t               slave_req_i,
  output periph_pkg::obi_resp_t              slave_resp_o,
  input  logic [periph_pkg::NUM_EXT_IRQ-1:0] intr_vector_ext_i,
  output logic                               irq_plic_o,
  output logic                               msip_o,
  output logic                               timer_irq_o,
  input  logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_i,
  output logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_o,
  output logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_en_o
);

  periph_pkg::reg_req_t                             periph_req;
  periph_pkg::reg_rsp_t                             periph_rsp;
  periph_pkg::reg_req_t [periph_pkg::NUM_PERIPH-1:0] slv_req;
  periph_pkg::reg_rsp_t [periph_pkg::NUM_PERIPH-1:0] slv_rsp;
  logic                                             gpio_irq;
  logic [periph_pkg::NUM_IRQ_SRC-1:0]               intr_vector;

  // Source 0 tied low, then GPIO, timer, external lines
  assign intr_vector = {intr_vector_ext_i, timer_irq_o, gpio_irq, 1'b0};

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_n_i,
    .obi_req_i  (slave_req_i),
    .obi_resp_o (slave_resp_o),
    .reg_req_o  (periph_req),
    .reg_rsp_i  (periph_rsp)
  );

  reg_demux reg_demux_i (
    .reg_req_i    (periph_req),
    .reg_rsp_o    (periph_rsp),
    .periph_req_o (slv_req),
    .periph_rsp_i (slv_rsp)
  );

  irq_ctrl irq_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (slv_req[periph_pkg::IRQ_CTRL_IDX]),
    .reg_rsp_o (slv_rsp[periph_pkg::IRQ_CTRL_IDX]),
    .irq_src_i (intr_vector),
    .irq_o     (irq_plic_o),
    .msip_o
  );

  gpio gpio_periph_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (slv_req[periph_pkg::GPIO_IDX]),
    .reg_rsp_o (slv_rsp[periph_pkg::GPIO_IDX]),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .irq_o     (gpio_irq)
  );

  rv_timer rv_timer_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (slv_req[periph_pkg::TIMER_IDX]),
    .reg_rsp_o (slv_rsp[periph_pkg::TIMER_IDX]),
    .irq_o     (timer_irq_o)
  );

endmodule

// ==== tb/tb_peripheral_subsystem.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the peripheral subsystem with bus tasks, LCG stimulus,
// reference model, OBI protocol monitor and watchdog
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_peripheral_subsystem;

  localparam int NUM_OPS         = 240;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 2000;

  logic                               clk_i;
  logic                               rst_n_i;
  periph_pkg::obi_req_t               slave_req_i;
  periph_pkg::obi_resp_t              slave_resp_o;
  logic [periph_pkg::NUM_EXT_IRQ-1:0] intr_vector_ext_i;
  logic                               irq_plic_o;
  logic                               msip_o;
  logic                               timer_irq_o;
  logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_i;
  logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_o;
  logic [periph_pkg::GPIO_WIDTH-1:0]  gpio_en_o;

  // Reference model state
  logic [31:0] m_data_out;
  logic [31:0] m_out_en;
  logic [31:0] m_intr_en;
  logic [31:0] m_status;
  logic [31:0] m_gpio_in;
  logic [63:0] m_cmp;
  logic        m_tim_en;
  logic [7:0]  m_pend;
  logic [7:0]  m_en;
  logic [7:0]  m_insvc;
  logic        m_msip;

  logic [31:0] lcg_state = 32'h05c0_45a2;
  int          value_errors = 0;
  int          protocol_errors = 0;
  int          outstanding = 0;
  int          waited;
  logic [31:0] r;
  logic [31:0] d;
  logic [31:0] rdata;
  logic [31:0] addr;
  logic [31:0] t0;
  logic [31:0] t1;
  logic [2:0]  id;
  logic        err;

  peripheral_subsystem UUT (
    .clk_i,
    .rst_n_i,
    .slave_req_i,
    .slave_resp_o,
    .intr_vector_ext_i,
    .irq_plic_o,
    .msip_o,
    .timer_irq_o,
    .gpio_i,
    .gpio_o,
    .gpio_en_o
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] be);
    logic [31:0] m;
    m = '0;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) m[8*b +: 8] = 8'hFF;
    end
    return m;
  endfunction

  // Lowest ID above 0 that is pending and enabled
  function automatic logic [2:0] lowest_claim(input logic [7:0] pend, input logic [7:0] en);
    for (int i = 1; i < 8; i++) begin
      if (pend[i] && en[i]) return 3'(i);
    end
    return '0;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic bus_access(input logic [31:0] a, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rd,
                            output logic er);
    int wait_gnt;
    int latency;
    rd = '0;
    er = 1'b0;
    @(posedge clk_i);
    slave_req_i.req   <= 1'b1;
    slave_req_i.we    <= we;
    slave_req_i.be    <= be;
    slave_req_i.addr  <= a;
    slave_req_i.wdata <= wdata;
    wait_gnt = 0;
    @(posedge clk_i);
    while (!slave_resp_o.gnt && wait_gnt < 20) begin
      @(posedge clk_i);
      wait_gnt++;
    end
    assert (slave_resp_o.gnt) else begin
      protocol_errors++;
      $display("No grant for the request to address %h", a);
    end
    slave_req_i.req <= 1'b0;
    latency = 0;
    do begin
      @(posedge clk_i);
      latency++;
    end while (!slave_resp_o.rvalid && latency < 10);
    assert (latency == 2) else begin
      protocol_errors++;
      $display("CHECK FAILED rvalid latency: got %h, expected %h", latency, 2);
    end
    rd = slave_resp_o.rdata;
    er = slave_resp_o.err;
  endtask

  task automatic write_reg(input logic [31:0] a, input logic [31:0] wdata,
                           input logic [3:0] be);
    logic [31:0] rd;
    logic        er;
    bus_access(a, 1'b1, be, wdata, rd, er);
    check_value("slave_resp_o.err", er, 0);
  endtask

  task automatic read_reg(input logic [31:0] a, output logic [31:0] rd);
    logic er;
    bus_access(a, 1'b0, 4'hF, '0, rd, er);
    check_value("slave_resp_o.err", er, 0);
  endtask

  task automatic pulse_ext(input logic [periph_pkg::NUM_EXT_IRQ-1:0] lines);
    @(posedge clk_i);
    intr_vector_ext_i <= lines;
    repeat (2) @(posedge clk_i);
    intr_vector_ext_i <= '0;
    @(posedge clk_i);
    // External lines are sources 3 and up
    for (int s = 0; s < periph_pkg::NUM_EXT_IRQ; s++) begin
      if (lines[s] && !m_insvc[s + 3]) m_pend[s + 3] = 1'b1;
    end
  endtask

  // OBI protocol monitor
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      assert (!slave_resp_o.rvalid || outstanding > 0) else begin
        protocol_errors++;
        $display("rvalid seen with no transfer outstanding at %0t", $time);
      end
      assert (!slave_resp_o.gnt || slave_resp_o.rvalid || outstanding == 0) else begin
        protocol_errors++;
        $display("gnt high while a transfer is outstanding at %0t", $time);
      end
      outstanding = outstanding + int'(slave_req_i.req && slave_resp_o.gnt)
                    - int'(slave_resp_o.rvalid);
    end
  end

  initial begin
    rst_n_i           = 1'b0;
    slave_req_i       = '0;
    intr_vector_ext_i = '0;
    gpio_i            = '0;
    m_data_out = '0;
    m_out_en   = '0;
    m_intr_en  = '0;
    m_status   = '0;
    m_gpio_in  = '0;
    m_cmp      = '1;
    m_tim_en   = 1'b0;
    m_pend     = '0;
    m_en       = '0;
    m_insvc    = '0;
    m_msip     = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_value("slave_resp_o.gnt", slave_resp_o.gnt, 1);
    check_value("slave_resp_o.rvalid", slave_resp_o.rvalid, 0);
    check_value("irq_plic_o", irq_plic_o, 0);
    check_value("msip_o", msip_o, 0);
    check_value("timer_irq_o", timer_irq_o, 0);
    check_value("gpio_o", gpio_o, 0);
    check_value("gpio_en_o", gpio_en_o, 0);

    // GPIO data with random byte enables
    for (int i = 0; i < 20; i++) begin
      r = next_rand();
      d = next_rand();
      if (r[4]) begin
        write_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_DATA_OUT, d, r[3:0]);
        m_data_out = (m_data_out & ~byte_mask(r[3:0])) | (d & byte_mask(r[3:0]));
        read_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_DATA_OUT, rdata);
        check_value("GPIO_DATA_OUT", rdata, m_data_out);
      end else begin
        write_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_OUT_EN, d, r[3:0]);
        m_out_en = (m_out_en & ~byte_mask(r[3:0])) | (d & byte_mask(r[3:0]));
        read_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_OUT_EN, rdata);
        check_value("GPIO_OUT_EN", rdata, m_out_en);
      end
      check_value("gpio_o", gpio_o, m_data_out);
      check_value("gpio_en_o", gpio_en_o, m_out_en);
    end
    for (int i = 0; i < 8; i++) begin
      d = next_rand();
      @(posedge clk_i);
      gpio_i <= d;
      m_gpio_in = d;
      repeat (3) @(posedge clk_i);
      read_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_DATA_IN, rdata);
      check_value("GPIO_DATA_IN", rdata, m_gpio_in);
    end

    // GPIO rising-edge interrupts and write-1-to-clear
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      write_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_INTR_EN, r, 4'hF);
      m_intr_en = r;
      d = next_rand();
      @(posedge clk_i);
      gpio_i <= d;
      repeat (5) @(posedge clk_i);
      m_status = m_status | (d & ~m_gpio_in & m_intr_en);
      m_gpio_in = d;
      if (m_status != 0 && !m_insvc[1]) m_pend[1] = 1'b1;
      read_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_INTR_STATUS, rdata);
      check_value("GPIO_INTR_STATUS", rdata, m_status);
      r = next_rand();
      d = next_rand();
      write_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_INTR_STATUS, d, r[3:0]);
      m_status = m_status & ~(d & byte_mask(r[3:0]));
      read_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_INTR_STATUS, rdata);
      check_value("GPIO_INTR_STATUS", rdata, m_status);
      read_reg(periph_pkg::IRQ_CTRL_BASE + periph_pkg::IRQ_PENDING, rdata);
      check_value("IRQ_PENDING", rdata, {24'b0, m_pend});
    end
    write_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_INTR_STATUS, 32'hFFFF_FFFF, 4'hF);
    m_status = '0;

    // Timer compare interrupt
    write_reg(periph_pkg::TIMER_BASE + periph_pkg::TIMER_CMP_HI, 32'h0, 4'hF);
    write_reg(periph_pkg::TIMER_BASE + periph_pkg::TIMER_CMP_LO, 32'd20, 4'hF);
    m_cmp = 64'd20;
    write_reg(periph_pkg::TIMER_BASE + periph_pkg::TIMER_CTRL, 32'h0000_0001, 4'h3);
    m_tim_en = 1'b1;
    waited = 0;
    while (!timer_irq_o && waited < 200) begin
      @(posedge clk_i);
      waited++;
    end
    assert (timer_irq_o) else begin
      value_errors++;
      $display("timer_irq_o did not rise within 200 cycles");
    end
    if (!m_insvc[2]) m_pend[2] = 1'b1;
    read_reg(periph_pkg::TIMER_BASE + periph_pkg::TIMER_MTIME_LO, t0);
    assert (t0 >= m_cmp[31:0]) else begin
      value_errors++;
      $display("CHECK FAILED mtime_lo: got %h, expected at least %h", t0, m_cmp[31:0]);
    end
    read_reg(periph_pkg::TIMER_BASE + periph_pkg::TIMER_MTIME_HI, rdata);
    check_value("TIMER_MTIME_HI", rdata, 0);
    for (int i = 0; i < 3; i++) begin
      read_reg(periph_pkg::TIMER_BASE + periph_pkg::TIMER_MTIME_LO, t1);
      assert (t1 > t0) else begin
        value_errors++;
        $display("CHECK FAILED mtime_lo: got %h, expected above %h", t1, t0);
      end
      t0 = t1;
    end
    read_reg(periph_pkg::TIMER_BASE + periph_pkg::TIMER_CTRL, rdata);
    check_value("TIMER_CTRL", rdata, {31'b0, m_tim_en});
    write_reg(periph_pkg::TIMER_BASE + periph_pkg::TIMER_CMP_HI, 32'h1, 4'hF);
    m_cmp[63:32] = 32'h1;
    check_value("timer_irq_o", timer_irq_o, 0);
    read_reg(periph_pkg::IRQ_CTRL_BASE + periph_pkg::IRQ_PENDING, rdata);
    check_value("IRQ_PENDING", rdata, {24'b0, m_pend});

    // Interrupt controller claim and complete
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      pulse_ext(r[4:0]);
      check_value("irq_plic_o", irq_plic_o, |(m_pend & m_en));
      r = next_rand();
      write_reg(periph_pkg::IRQ_CTRL_BASE + periph_pkg::IRQ_ENABLE, r, 4'hF);
      m_en = r[7:0];
      check_value("irq_plic_o", irq_plic_o, |(m_pend & m_en));
      read_reg(periph_pkg::IRQ_CTRL_BASE + periph_pkg::IRQ_PENDING, rdata);
      check_value("IRQ_PENDING", rdata, {24'b0, m_pend});
      id = lowest_claim(m_pend, m_en);
      read_reg(periph_pkg::IRQ_CTRL_BASE + periph_pkg::IRQ_CLAIM, rdata);
      check_value("IRQ_CLAIM", rdata, {29'b0, id});
      if (id != 0) begin
        m_pend[id]  = 1'b0;
        m_insvc[id] = 1'b1;
      end
      check_value("irq_plic_o", irq_plic_o, |(m_pend & m_en));
      r = next_rand();
      if (r[0]) begin
        id = 3'((r[15:8] % 7) + 1);
        write_reg(periph_pkg::IRQ_CTRL_BASE + periph_pkg::IRQ_CLAIM, {29'b0, id}, 4'hF);
        m_insvc[id] = 1'b0;
      end
      write_reg(periph_pkg::IRQ_CTRL_BASE + periph_pkg::IRQ_MSIP, {31'b0, r[1]}, 4'hF);
      m_msip = r[1];
      check_value("msip_o", msip_o, m_msip);
    end

    // Unmapped addresses
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      addr = {r[31:2], 2'b00};
      if (addr >= 32'h2000_0000 && addr < 32'h2000_3000) addr = addr ^ 32'h8000_0000;
      d = next_rand();
      bus_access(addr, d[0], 4'hF, next_rand(), rdata, err);
      check_value("slave_resp_o.err", err, 1);
      check_value("slave_resp_o.rdata", rdata, 0);
    end
    read_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_DATA_OUT, rdata);
    check_value("GPIO_DATA_OUT", rdata, m_data_out);
    read_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_OUT_EN, rdata);
    check_value("GPIO_OUT_EN", rdata, m_out_en);
    read_reg(periph_pkg::GPIO_BASE + periph_pkg::GPIO_INTR_EN, rdata);
    check_value("GPIO_INTR_EN", rdata, m_intr_en);
    read_reg(periph_pkg::TIMER_BASE + periph_pkg::TIMER_CMP_HI, rdata);
    check_value("TIMER_CMP_HI", rdata, m_cmp[63:32]);
    read_reg(periph_pkg::IRQ_CTRL_BASE + periph_pkg::IRQ_ENABLE, rdata);
    check_value("IRQ_ENABLE", rdata, {24'b0, m_en});
    read_reg(periph_pkg::IRQ_CTRL_BASE + periph_pkg::IRQ_PENDING, rdata);
    check_value("IRQ_PENDING", rdata, {24'b0, m_pend});
    read_reg(periph_pkg::IRQ_CTRL_BASE + periph_pkg::IRQ_MSIP, rdata);
    check_value("IRQ_MSIP", rdata, {31'b0, m_msip});
    check_value("gpio_o", gpio_o, m_data_out);

    $display("Error counts: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/periph_pkg.sv
verilog/obi_to_reg.sv
verilog/reg_demux.sv
verilog/gpio.sv
verilog/rv_timer.sv
verilog/irq_ctrl.sv
verilog/peripheral_subsystem.sv
tb/tb_peripheral_subsystem.sv
